//--- tb.f
hw/reorder_pkg.sv
hw/rob_dualport_ram.sv
hw/rob_ctrl.sv
hw/read_reorder_top.sv
bench/rob_props.sv
bench/rob_checker.sv
bench/tb_read_reorder.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_read_reorder
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/tb_read_reorder.sv
// Testbench for the read reorder buffer with an out-of-order memory model.
// Runs five tests through the DUT and prints the verdict at the end.

`timescale 1ns/100ps

module tb_read_reorder
    import reorder_pkg::*;
();

    localparam int N_ENTRIES       = 16;
    localparam int MIN_FREE_SLOTS  = 1;
    localparam int IDX_BITS        = $clog2(N_ENTRIES);
    localparam int FILL_LEVEL      = N_ENTRIES - MIN_FREE_SLOTS;
    localparam int RANDOM_REQUESTS = 200;

    // Requests per test: single, in order, reverse, fill and random
    localparam int TOTAL_REQUESTS  = 1 + 8 + 8 + FILL_LEVEL + RANDOM_REQUESTS;
    localparam int WATCHDOG_CYCLES = TOTAL_REQUESTS * (N_ENTRIES + 10);

    logic                 clk = 1'b0;
    logic                 reset_n;
    logic                 req_valid;
    rd_req_t              req;
    logic                 not_full;
    logic                 mem_req_valid;
    logic [ADDR_BITS-1:0] mem_req_addr;
    logic [IDX_BITS-1:0]  mem_req_idx;
    logic                 mem_rsp_valid;
    logic [IDX_BITS-1:0]  mem_rsp_idx;
    logic [DATA_BITS-1:0] mem_rsp_data;
    logic                 rsp_valid;
    rd_rsp_t              rsp;

    // A memory request that has been issued and not answered yet
    typedef struct packed
    {
        logic [IDX_BITS-1:0]  idx;
        logic [ADDR_BITS-1:0] addr;
    }
    issued_t;

    issued_t pending[$];
    integer  seed = 12;

    always
    begin
        #20 clk = ~clk;
    end

    read_reorder_top #(
        .N_ENTRIES      (N_ENTRIES),
        .MIN_FREE_SLOTS (MIN_FREE_SLOTS)
    ) dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .req_valid     (req_valid),
        .req           (req),
        .not_full      (not_full),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_idx   (mem_req_idx),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_idx   (mem_rsp_idx),
        .mem_rsp_data  (mem_rsp_data),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp)
    );

    rob_checker chk (
        .clk       (clk),
        .reset_n   (reset_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    // Memory model input side, collects every issued index with its address
    always @(posedge clk)
    begin
        if (reset_n && mem_req_valid)
        begin
            pending.push_back({mem_req_idx, mem_req_addr});
        end
    end

    // Strobes last one cycle and change 2 ns after the edge
    task automatic tick();
        @(posedge clk);
        #2;
        req_valid     = 1'b0;
        mem_rsp_valid = 1'b0;
    endtask

    task automatic put_request(logic [ADDR_BITS-1:0] addr, logic [META_BITS-1:0] meta);
        req_valid = 1'b1;
        req.addr  = addr;
        req.meta  = meta;
    endtask

    // Answers the pending request at a queue position, which sets the answer order
    task automatic put_answer(int pos);
        mem_rsp_valid = 1'b1;
        mem_rsp_idx   = pending[pos].idx;
        mem_rsp_data  = chk.expected_data(pending[pos].addr);
        pending.delete(pos);
    endtask

    task automatic wait_pending(int count);
        while (pending.size() < count)
        begin
            tick();
        end
    endtask

    task automatic wait_drain();
        while (chk.outstanding() > 0)
        begin
            tick();
        end
    endtask

    function automatic int pick(int range);
        return int'($unsigned($random(seed)) % range);
    endfunction

    initial
    begin
        int count;
        int issued;
        reset_n       = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp_idx   = '0;
        mem_rsp_data  = '0;
        repeat (5) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // One request answered at once, and the memory side timing
        chk.begin_test("single");
        chk.check_value("not_full after reset", 64'd1, 64'(not_full));
        put_request(32'h0000_1000, 8'h11);
        tick();
        chk.check_value("mem_req_valid one cycle after req_valid", 64'd1, 64'(mem_req_valid));
        chk.check_value("first mem_req_idx", 64'd0, 64'(mem_req_idx));
        wait_pending(1);
        put_answer(0);
        tick();
        wait_drain();
        chk.end_test();

        chk.begin_test("in_order");
        for (int i = 0; i < 8; i++)
        begin
            put_request(32'h0000_2000 + 32'(i * 8), 8'(32 + i));
            tick();
        end
        wait_pending(8);
        while (pending.size() > 0)
        begin
            put_answer(0);
            tick();
        end
        wait_drain();
        chk.end_test();

        // Newest answered first, so nothing may come out before the oldest answer
        chk.begin_test("reverse");
        for (int i = 0; i < 8; i++)
        begin
            put_request(32'h0003_0000 + 32'(i * 64), 8'(64 + i));
            tick();
        end
        wait_pending(8);
        count = chk.replies_seen;
        while (pending.size() > 1)
        begin
            put_answer(pending.size() - 1);
            tick();
        end
        repeat (3) tick();
        chk.check_value("replies before the oldest answer", 64'(count), 64'(chk.replies_seen));
        put_answer(0);
        tick();
        wait_drain();
        chk.end_test();

        // No answers until the client has to stop
        chk.begin_test("fill");
        count = 0;
        while (not_full)
        begin
            put_request(32'h0004_0000 + 32'(count * 16), 8'(96 + count));
            tick();
            count++;
        end
        chk.check_value("allocations until not_full low", 64'(FILL_LEVEL), 64'(count));
        wait_pending(count);
        while (pending.size() > 0)
        begin
            put_answer(pick(pending.size()));
            tick();
        end
        wait_drain();
        chk.check_value("not_full after drain", 64'd1, 64'(not_full));
        chk.end_test();

        // Mixed traffic with shuffled answers over many pointer wraps
        chk.begin_test("random");
        issued = 0;
        while (issued < RANDOM_REQUESTS || chk.outstanding() > 0)
        begin
            if (issued < RANDOM_REQUESTS && not_full && pick(2) == 0)
            begin
                put_request(32'($random(seed)), 8'(issued));
                issued++;
            end
            if (pending.size() > 0 && pick(3) != 0)
            begin
                put_answer(pick(pending.size()));
            end
            tick();
        end
        chk.end_test();

        chk.report();
        if (chk.errors == 0 && dut.ctrl.props.failures == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Each request gets a generous share of cycles, reset included
    initial
    begin
        repeat (WATCHDOG_CYCLES + 5) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- bench/rob_checker.sv
// Scoreboard for the read reorder buffer testbench.
// Records accepted requests in issue order and checks every ordered reply against them.

`timescale 1ns/100ps

module rob_checker
    import reorder_pkg::*;
(
    input logic    clk,
    input logic    reset_n,
    input logic    req_valid,
    input rd_req_t req,
    input logic    rsp_valid,
    input rd_rsp_t rsp
);

    // Requests the buffer accepted and has not returned yet, oldest first
    rd_req_t expected[$];

    string test_name    = "reset";
    int    test_errors  = 0;
    int    test_replies = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    errors       = 0;
    int    replies_seen = 0;

    // What memory returns for an address: the address in the upper half,
    // and its inversion scaled by an odd constant in the lower half
    function automatic logic [DATA_BITS-1:0] expected_data(logic [ADDR_BITS-1:0] addr);
        logic [ADDR_BITS-1:0] mixed;
        mixed = ~addr * 32'h9e37_79b1;
        return {addr, mixed};
    endfunction

    function automatic int outstanding();
        return expected.size();
    endfunction

    task automatic check_value(string what, logic [DATA_BITS-1:0] want,
                               logic [DATA_BITS-1:0] got);
        if (want !== got)
        begin
            $display("error in test %s: %s, expected 0x%0h, actual 0x%0h",
                     test_name, what, want, got);
            test_errors++;
            errors++;
        end
    endtask

    task automatic report_problem(string what);
        $display("test %s went wrong: %s", test_name, what);
        test_errors++;
        errors++;
    endtask

    task automatic begin_test(string name);
        test_name    = name;
        test_errors  = 0;
        test_replies = 0;
    endtask

    task automatic end_test();
        if (expected.size() != 0)
        begin
            report_problem($sformatf("%0d replies never came back", expected.size()));
        end
        if (test_errors == 0)
        begin
            $display("test %s passed with %0d replies", test_name, test_replies);
            tests_passed++;
        end
        else
        begin
            $display("test %s failed with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic report();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
    endtask

    // Pre-edge values are sampled here, so replies are popped before new requests land
    always @(posedge clk)
    begin
        rd_req_t oldest;
        if (reset_n)
        begin
            if (rsp_valid)
            begin
                if (expected.size() == 0)
                begin
                    report_problem("a reply came with no request outstanding");
                end
                else
                begin
                    oldest = expected.pop_front();
                    check_value("reply data", expected_data(oldest.addr), rsp.data);
                    check_value("reply meta", 64'(oldest.meta), 64'(rsp.meta));
                    test_replies++;
                    replies_seen++;
                end
            end
            if (req_valid)
            begin
                expected.push_back(req);
            end
        end
    end

endmodule

//--- bench/rob_props.sv
// Concurrent assertions on the reorder buffer control, bound into every rob_ctrl instance.
// Covers the client handshake rule, duplicate memory answers and the fixed pipeline delays.

`timescale 1ns/100ps

module rob_props
#(
    parameter int N_ENTRIES = 16
)
(
    input logic                         clk,
    input logic                         reset_n,
    input logic                         req_valid,
    input logic                         not_full,
    input logic                         mem_req_valid,
    input logic                         mem_rsp_valid,
    input logic [$clog2(N_ENTRIES)-1:0] mem_rsp_idx,
    input logic [N_ENTRIES-1:0]         arrived,
    input logic [$clog2(N_ENTRIES):0]   oldest_next,
    input logic                         rsp_valid
);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    // Number of assertion failures so far
    int failures = 0;

    // Memory answers the slot that both RAMs will read next, i.e. the oldest one
    logic oldest_arrives;

    assign oldest_arrives = mem_rsp_valid && (mem_rsp_idx == oldest_next[IDX_BITS-1:0]);

    // The client must respect not_full before it strobes
    req_respects_full: assert property (@(posedge clk) disable iff (!reset_n)
        req_valid |-> not_full)
    else
    begin
        failures++;
        $error("req_valid strobed while not_full was low");
    end

    // Each slot gets exactly one answer per allocation
    single_answer: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rsp_valid |-> !arrived[mem_rsp_idx])
    else
    begin
        failures++;
        $error("memory answered a slot whose data had already arrived");
    end

    // The memory request register adds one cycle, no more and no less
    mem_req_delay: assert property (@(posedge clk) disable iff (!reset_n)
        mem_req_valid == $past(req_valid))
    else
    begin
        failures++;
        $error("mem_req_valid did not follow req_valid by one cycle");
    end

    // Data captured for the oldest slot is dequeued one cycle later
    // and reaches the reply register one cycle after that.
    // Sampled values see the raised rsp_valid three edges after the capture
    reply_delay: assert property (@(posedge clk) disable iff (!reset_n)
        $past(oldest_arrives, 3) |-> rsp_valid)
    else
    begin
        failures++;
        $error("rsp_valid missing two cycles after the oldest slot's data arrived");
    end

endmodule

bind rob_ctrl rob_props #(
    .N_ENTRIES (N_ENTRIES)
) props (
    .clk           (clk),
    .reset_n       (reset_n),
    .req_valid     (req_valid),
    .not_full      (not_full),
    .mem_req_valid (mem_req_valid),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_idx   (mem_rsp_idx),
    .arrived       (arrived),
    .oldest_next   (oldest_next),
    .rsp_valid     (rsp_valid)
);

//--- hw/read_reorder_top.sv
// Top level of the read reorder buffer: the controller plus data and tag storage.
// Set N_ENTRIES and MIN_FREE_SLOTS here, they are passed down to every block.

`timescale 1ns/100ps

module read_reorder_top
    import reorder_pkg::*;
#(
    parameter int N_ENTRIES      = 16,
    parameter int MIN_FREE_SLOTS = 1
)
(
    input  logic                         clk,
    input  logic                         reset_n,

    // Client request
    input  logic                         req_valid,
    input  rd_req_t                      req,
    output logic                         not_full,

    // Memory request
    output logic                         mem_req_valid,
    output logic [ADDR_BITS-1:0]         mem_req_addr,
    output logic [$clog2(N_ENTRIES)-1:0] mem_req_idx,

    // Memory response, in any order
    input  logic                         mem_rsp_valid,
    input  logic [$clog2(N_ENTRIES)-1:0] mem_rsp_idx,
    input  logic [DATA_BITS-1:0]         mem_rsp_data,

    // Client reply, in request order
    output logic                         rsp_valid,
    output rd_rsp_t                      rsp
);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    // Tag write at allocation time
    logic                 meta_wen;
    logic [IDX_BITS-1:0]  meta_waddr;
    logic [META_BITS-1:0] meta_wdata;

    // Common read address and the two registered read words
    logic [IDX_BITS-1:0]  rd_addr;
    logic [DATA_BITS-1:0] data_rdata;
    logic [META_BITS-1:0] meta_rdata;

    rob_ctrl #(
        .N_ENTRIES      (N_ENTRIES),
        .MIN_FREE_SLOTS (MIN_FREE_SLOTS)
    ) ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .req_valid      (req_valid),
        .req            (req),
        .not_full       (not_full),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_idx    (mem_req_idx),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_idx    (mem_rsp_idx),
        .meta_wen       (meta_wen),
        .meta_waddr     (meta_waddr),
        .meta_wdata     (meta_wdata),
        .rd_addr        (rd_addr),
        .data_rdata     (data_rdata),
        .meta_rdata     (meta_rdata),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp)
    );

    // Memory writes its answer straight into the slot named by its index
    rob_dualport_ram #(
        .N_ENTRIES (N_ENTRIES),
        .WIDTH     (DATA_BITS)
    ) data_ram (
        .clk   (clk),
        .waddr (mem_rsp_idx),
        .wen   (mem_rsp_valid),
        .wdata (mem_rsp_data),
        .raddr (rd_addr),
        .rdata (data_rdata)
    );

    // Client tags, written when the slot is allocated
    rob_dualport_ram #(
        .N_ENTRIES (N_ENTRIES),
        .WIDTH     (META_BITS)
    ) meta_ram (
        .clk   (clk),
        .waddr (meta_waddr),
        .wen   (meta_wen),
        .wdata (meta_wdata),
        .raddr (rd_addr),
        .rdata (meta_rdata)
    );

endmodule

//--- hw/rob_ctrl.sv
// Control for the read reorder buffer: slot allocation, arrival tracking and ordered drain.
// Sits between the client, memory and the two slot RAMs instantiated by the top level.

`timescale 1ns/100ps

module rob_ctrl
    import reorder_pkg::*;
#(
    parameter int N_ENTRIES      = 16,
    parameter int MIN_FREE_SLOTS = 1
)
(
    input  logic                         clk,
    input  logic                         reset_n,

    // Client request side, req_valid only while not_full is high
    input  logic                         req_valid,
    input  rd_req_t                      req,
    output logic                         not_full,

    // Request to memory, tagged with the slot index
    output logic                         mem_req_valid,
    output logic [ADDR_BITS-1:0]         mem_req_addr,
    output logic [$clog2(N_ENTRIES)-1:0] mem_req_idx,

    // Memory response, the data itself goes straight to the data RAM
    input  logic                         mem_rsp_valid,
    input  logic [$clog2(N_ENTRIES)-1:0] mem_rsp_idx,

    // Meta RAM write, done when the slot is allocated
    output logic                         meta_wen,
    output logic [$clog2(N_ENTRIES)-1:0] meta_waddr,
    output logic [META_BITS-1:0]         meta_wdata,

    // Shared read address for both RAMs and their registered read data
    output logic [$clog2(N_ENTRIES)-1:0] rd_addr,
    input  logic [DATA_BITS-1:0]         data_rdata,
    input  logic [META_BITS-1:0]         meta_rdata,

    // Ordered reply to the client
    output logic                         rsp_valid,
    output rd_rsp_t                      rsp
);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    // Pointers live in a space one bit wider than the slot index,
    // so a full ring and an empty ring look different after a wrap
    localparam int PTR_BITS = IDX_BITS + 1;

    // Occupancy at which the client is told to stop
    localparam logic [PTR_BITS-1:0] FULL_LEVEL = PTR_BITS'(N_ENTRIES - MIN_FREE_SLOTS);

    // Next slot to allocate and oldest slot not yet returned
    logic [PTR_BITS-1:0]  newest;
    logic [PTR_BITS-1:0]  oldest;

    // Oldest pointer as it will be after this cycle's dequeue
    logic [PTR_BITS-1:0]  oldest_next;

    // Number of allocated slots not yet dequeued
    logic [PTR_BITS-1:0]  occupancy;

    // One bit per slot, set when memory has answered for that slot
    logic [N_ENTRIES-1:0] arrived;

    // Registered: the oldest slot's data has arrived and is on the RAM outputs
    logic                 not_empty;

    // Dequeue strobe for the oldest slot
    logic                 deq;

    // Allocation side

    // Subtraction wraps correctly thanks to the extra pointer bit
    assign occupancy = newest - oldest;

    // Built from registered pointers only, so it follows an allocation
    // or a dequeue by one cycle
    assign not_full = (occupancy < FULL_LEVEL);

    // The tag is stored at the newest slot in the cycle it is allocated
    assign meta_wen   = req_valid;
    assign meta_waddr = newest[IDX_BITS-1:0];
    assign meta_wdata = req.meta;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            newest <= '0;
        end
        else if (req_valid)
        begin
            newest <= newest + PTR_BITS'(1);
        end
    end

    // Memory request register, valid exactly one cycle after req_valid
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mem_req_valid <= 1'b0;
        end
        else
        begin
            mem_req_valid <= req_valid;
        end
    end

    // Payload of the memory request, held between requests
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            mem_req_addr <= req.addr;
            mem_req_idx  <= newest[IDX_BITS-1:0];
        end
    end

    // Drain side

    // Drain is automatic, the oldest slot leaves as soon as it is ready
    assign deq = not_empty;

    assign oldest_next = oldest + PTR_BITS'(deq);

    // Both RAMs look ahead at the slot that will be oldest next cycle,
    // so their read data lines up with not_empty
    assign rd_addr = oldest_next[IDX_BITS-1:0];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            oldest <= '0;
        end
        else
        begin
            oldest <= oldest_next;
        end
    end

    // Arrival bits.
    // A dequeued slot is cleared, and a memory answer marks its slot.
    // The two never hit the same slot since memory answers each index
    // once before it is issued again
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            arrived <= '0;
        end
        else
        begin
            if (deq)
            begin
                arrived[oldest[IDX_BITS-1:0]] <= 1'b0;
            end

            if (mem_rsp_valid)
            begin
                arrived[mem_rsp_idx] <= 1'b1;
            end
        end
    end

    // Sampled at the same edge as the RAM read, so a bit set at this
    // edge is seen one cycle later together with the new RAM data
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            not_empty <= 1'b0;
        end
        else
        begin
            not_empty <= arrived[oldest_next[IDX_BITS-1:0]];
        end
    end

    // Client reply register, one cycle after the dequeue
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= deq;
        end
    end

    // Reply payload is taken from the RAM outputs of the dequeued slot
    always_ff @(posedge clk)
    begin
        if (deq)
        begin
            rsp.data <= data_rdata;
            rsp.meta <= meta_rdata;
        end
    end

endmodule

//--- hw/rob_dualport_ram.sv
// Simple dual-port storage array with one write port and one registered read port.
// Used by the reorder buffer for both the read data and the client tags.

`timescale 1ns/100ps

module rob_dualport_ram
#(
    parameter int N_ENTRIES = 16,
    parameter int WIDTH     = 64
)
(
    input  logic                         clk,

    // Write port, one word per cycle when wen is high
    input  logic [$clog2(N_ENTRIES)-1:0] waddr,
    input  logic                         wen,
    input  logic [WIDTH-1:0]             wdata,

    // Read port, data appears one cycle after the address
    input  logic [$clog2(N_ENTRIES)-1:0] raddr,
    output logic [WIDTH-1:0]             rdata
);

    // The array itself, one word per slot
    logic [WIDTH-1:0] mem [N_ENTRIES];

    // Synchronous write
    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read.
    // A read and a write to the same address in one cycle return the old word,
    // and the caller's arrival tracking lags by the same cycle to match
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

//--- hw/reorder_pkg.sv
// Shared widths and payload structs for the read reorder buffer.
// Modules that carry client requests or ordered replies import this package.

package reorder_pkg;

    // Width of a read address as issued by the client
    parameter int ADDR_BITS = 32;

    // Width of one read data word returned by memory
    parameter int DATA_BITS = 64;

    // Width of the client tag that rides along with each request
    parameter int META_BITS = 8;

    // A client read request, 40 bits in total.
    // The address goes to memory, while the tag stays in the buffer
    // and is handed back with the data
    typedef struct packed
    {
        logic [ADDR_BITS-1:0] addr;
        logic [META_BITS-1:0] meta;
    }
    rd_req_t;

    // An ordered reply to the client, 72 bits in total.
    // Data comes from the slot storage and meta from the tag storage,
    // both read for the same slot in the same cycle
    typedef struct packed
    {
        logic [DATA_BITS-1:0] data;
        logic [META_BITS-1:0] meta;
    }
    rd_rsp_t;

endpackage
